// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_lsu
FILELIST  ?= lsu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then exit 1; fi
	@grep -q "Result: PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: lsu.f
+incdir+.
lsu_pkg.sv
lsu_fsm.sv
lsu_wait_timer.sv
lsu_store_align.sv
lsu_load_extend.sv
lsu_top.sv
tb_obi_mem.sv
tb_lsu.sv

// File: lsu_consts.svh
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// data and address width
`define LSU_XLEN 32

// cycles allowed for grant plus response before a bus error
`define LSU_TIMEOUT_CYCLES 16

// wide enough to hold the timeout value
`define LSU_TIMER_W 5

`endif

// File: lsu_fsm.sv
`timescale 1ns/1ps

module lsu_fsm (
    input  logic CLK,
    input  logic RSTn,
    input  logic mem_req,
    input  logic hz_data_req,
    input  logic misaligned,
    input  logic obi_gnt,
    input  logic obi_rvalid,
    input  logic timer_expired,
    output logic obi_req,
    output logic busy,
    output logic timer_run,
    output logic timer_clear,
    output logic misaligned_err,
    output logic bus_err
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait_gnt,
        st_wait_valid
    } state_e;

    state_e state;
    state_e next_state;
    logic   start;

    // request qualified by the hazard unit
    assign start = mem_req && hz_data_req;

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state     = state;
        obi_req        = 1'b0;
        busy           = 1'b0;
        timer_run      = 1'b0;
        timer_clear    = 1'b0;
        misaligned_err = 1'b0;
        bus_err        = 1'b0;
        case (state)
            st_idle: begin
                timer_clear = 1'b1;
                if (start && misaligned) begin
                    // reported, never issued
                    misaligned_err = 1'b1;
                end else if (start) begin
                    obi_req    = 1'b1;
                    busy       = 1'b1;
                    next_state = obi_gnt ? st_wait_valid : st_wait_gnt;
                end
            end
            st_wait_gnt: begin
                timer_run = 1'b1;
                if (timer_expired) begin
                    bus_err    = 1'b1;
                    next_state = st_idle;
                end else begin
                    // hold the request until the memory takes it
                    obi_req = 1'b1;
                    busy    = 1'b1;
                    if (obi_gnt) begin
                        next_state = st_wait_valid;
                    end
                end
            end
            st_wait_valid: begin
                timer_run = 1'b1;
                if (obi_rvalid) begin
                    // response cycle, busy already low here
                    next_state = st_idle;
                end else if (timer_expired) begin
                    bus_err    = 1'b1;
                    next_state = st_idle;
                end else begin
                    busy = 1'b1;
                end
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    // request held across cycles until granted or timed out
    req_hold_a: assert property (@(posedge CLK) disable iff (!RSTn)
        (obi_req && !obi_gnt) |=> (obi_req || bus_err));

    // no stall from an idle unit without a request
    idle_busy_a: assert property (@(posedge CLK) disable iff (!RSTn)
        (state == st_idle && !start) |-> !busy);

endmodule

// File: lsu_load_extend.sv
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_load_extend (
    input  logic [1:0]            addr_lsb,
    input  lsu_pkg::mem_size_e    size,
    input  logic                  is_unsigned,
    input  logic [`LSU_XLEN-1:0]  bus_rdata,
    output logic [`LSU_XLEN-1:0]  rdata
);

    import lsu_pkg::*;

    lsu_word_u  word;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    logic        byte_fill;
    logic        half_fill;

    assign word = bus_rdata;

    // lane picked by the low address bits
    assign sel_byte = word.bytes[addr_lsb];
    assign sel_half = word.halves[addr_lsb[1]];

    // fill bit is the sign bit unless the load is unsigned
    assign byte_fill = !is_unsigned && sel_byte[7];
    assign half_fill = !is_unsigned && sel_half[15];

    always_comb begin
        case (size)
            size_byte: begin
                rdata = {{(`LSU_XLEN-8){byte_fill}}, sel_byte};
            end
            size_half: begin
                rdata = {{(`LSU_XLEN-16){half_fill}}, sel_half};
            end
            default: begin
                // word loads pass straight through
                rdata = bus_rdata;
            end
        endcase
    end

endmodule

// File: lsu_pkg.sv
`include "lsu_consts.svh"

package lsu_pkg;

    // access size as encoded by the decoder
    typedef enum logic [1:0] {
        size_byte = 2'b00,
        size_half = 2'b01,
        size_word = 2'b10
    } mem_size_e;

    // one bus word, seen as byte lanes or halfword lanes
    typedef union packed {
        logic [`LSU_XLEN/8-1:0][7:0]   bytes;
        logic [`LSU_XLEN/16-1:0][15:0] halves;
    } lsu_word_u;

endpackage

// File: lsu_store_align.sv
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_store_align (
    input  logic [1:0]            addr_lsb,
    input  lsu_pkg::mem_size_e    size,
    input  logic [`LSU_XLEN-1:0]  wdata,
    output logic                  misaligned,
    output logic [3:0]            be,
    output logic [`LSU_XLEN-1:0]  lane_wdata
);

    import lsu_pkg::*;

    lsu_word_u lanes;

    always_comb begin
        misaligned = 1'b0;
        be         = 4'b0000;
        lanes      = '0;
        case (size)
            size_byte: begin
                be                     = 4'b0001 << addr_lsb;
                lanes.bytes[addr_lsb]  = wdata[7:0];
            end
            size_half: begin
                // halfword must sit on an even address
                misaligned               = addr_lsb[0];
                be                       = addr_lsb[1] ? 4'b1100 : 4'b0011;
                lanes.halves[addr_lsb[1]] = wdata[15:0];
            end
            size_word: begin
                misaligned = |addr_lsb;
                be         = 4'b1111;
                lanes      = wdata;
            end
            default: begin
                // unused size code, treat as a bad access
                misaligned = 1'b1;
            end
        endcase
    end

    assign lane_wdata = lanes;

    // some lane is always enabled for a legal access
    be_nonzero_a: assert final ($isunknown({size, addr_lsb}) || misaligned || (be != 4'b0000));

endmodule

// File: lsu_top.sv
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_top (
    input  logic                  CLK,
    input  logic                  RSTn,
    // datapath and hazard unit
    input  logic                  mem_req,
    input  logic                  hz_data_req,
    input  logic                  mem_we,
    input  lsu_pkg::mem_size_e    mem_size,
    input  logic                  mem_unsigned,
    input  logic [`LSU_XLEN-1:0]  addr,
    input  logic [`LSU_XLEN-1:0]  wdata,
    output logic [`LSU_XLEN-1:0]  rdata,
    output logic                  busy,
    output logic                  misaligned_err,
    output logic                  bus_err,
    // data bus
    output logic                  obi_req,
    output logic                  obi_we,
    output logic [`LSU_XLEN-1:0]  obi_addr,
    output logic [3:0]            obi_be,
    output logic [`LSU_XLEN-1:0]  obi_wdata,
    input  logic                  obi_gnt,
    input  logic                  obi_rvalid,
    input  logic [`LSU_XLEN-1:0]  obi_rdata
);

    logic misaligned;
    logic timer_run;
    logic timer_clear;
    logic timer_expired;

    // inputs are held stable by the stall, so no bus registers
    assign obi_addr = {addr[`LSU_XLEN-1:2], 2'b00};
    assign obi_we   = mem_we;

    lsu_store_align store_align0 (
        .addr_lsb   (addr[1:0]),
        .size       (mem_size),
        .wdata      (wdata),
        .misaligned (misaligned),
        .be         (obi_be),
        .lane_wdata (obi_wdata)
    );

    lsu_fsm fsm0 (
        .CLK            (CLK),
        .RSTn           (RSTn),
        .mem_req        (mem_req),
        .hz_data_req    (hz_data_req),
        .misaligned     (misaligned),
        .obi_gnt        (obi_gnt),
        .obi_rvalid     (obi_rvalid),
        .timer_expired  (timer_expired),
        .obi_req        (obi_req),
        .busy           (busy),
        .timer_run      (timer_run),
        .timer_clear    (timer_clear),
        .misaligned_err (misaligned_err),
        .bus_err        (bus_err)
    );

    lsu_wait_timer wait_timer0 (
        .CLK     (CLK),
        .RSTn    (RSTn),
        .run     (timer_run),
        .clear   (timer_clear),
        .expired (timer_expired)
    );

    lsu_load_extend load_extend0 (
        .addr_lsb    (addr[1:0]),
        .size        (mem_size),
        .is_unsigned (mem_unsigned),
        .bus_rdata   (obi_rdata),
        .rdata       (rdata)
    );

endmodule

// File: lsu_wait_timer.sv
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_wait_timer (
    input  logic CLK,
    input  logic RSTn,
    input  logic run,
    input  logic clear,
    output logic expired
);

    logic [`LSU_TIMER_W-1:0] count;
    logic                    at_max;

    // stop at all ones so the count never wraps back to zero
    assign at_max = &count;

    always_ff @(posedge CLK) begin
        if (!RSTn) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (run && !at_max) begin
            count <= count + 1'b1;
        end
    end

    assign expired = (count == `LSU_TIMER_W'(`LSU_TIMEOUT_CYCLES));

    // a cleared count needs several cycles before it can expire
    clear_expired_a: assert property (@(posedge CLK) disable iff (!RSTn)
        clear |=> !expired);

endmodule

// File: tb_lsu.sv
`timescale 1ns/1ps
`include "lsu_consts.svh"

module tb_lsu;

    import lsu_pkg::*;

    // one access at worst: full timeout, both model delays, some slack
    localparam int MAX_DELAY    = 4;
    localparam int ACCESS_LEN   = `LSU_TIMEOUT_CYCLES + 2 * MAX_DELAY + 4;
    localparam int ACCESS_COUNT = 64;
    localparam int WATCHDOG_NS  = ACCESS_COUNT * ACCESS_LEN * 4 * 2;

    logic                 CLK;
    logic                 RSTn;
    logic                 mem_req;
    logic                 hz_data_req;
    logic                 mem_we;
    mem_size_e            mem_size;
    logic                 mem_unsigned;
    logic [`LSU_XLEN-1:0] addr;
    logic [`LSU_XLEN-1:0] wdata;
    logic [`LSU_XLEN-1:0] rdata;
    logic                 busy;
    logic                 misaligned_err;
    logic                 bus_err;
    logic                 obi_req;
    logic                 obi_we;
    logic [`LSU_XLEN-1:0] obi_addr;
    logic [3:0]           obi_be;
    logic [`LSU_XLEN-1:0] obi_wdata;
    logic                 obi_gnt;
    logic                 obi_rvalid;
    logic [`LSU_XLEN-1:0] obi_rdata;
    logic [3:0]           gnt_delay;
    logic [3:0]           rsp_delay;
    logic                 mute;
    logic [7:0]           ref_mem [0:1023];
    int                   errors;
    int                   checks;

    lsu_top dut0 (.*);
    tb_obi_mem mem0 (.*);

    initial begin
        CLK = 1'b0;
        forever begin
            #2 CLK = ~CLK;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog: run still going after %0d ns, an access never finished", WATCHDOG_NS);
        $display("Result: FAILED");
        $finish;
    end

    task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // same pattern in the model and the reference, every address bit counts
    task automatic preload();
        logic [31:0] w;
        for (int i = 0; i < 256; i++) begin
            w = 32'(i + 1) * 32'h9e37_79b9;
            mem0.mem[i] = w;
            for (int b = 0; b < 4; b++) begin
                ref_mem[4*i + b] = w[8*b +: 8];
            end
        end
    endtask

    function automatic logic [3:0] expect_be(mem_size_e size, logic [1:0] lsb);
        case (size)
            size_byte: return 4'b0001 << lsb;
            size_half: return 4'b0011 << lsb;
            default:   return 4'b1111;
        endcase
    endfunction

    function automatic void ref_store(mem_size_e size, logic [9:0] a, logic [31:0] wd);
        int n;
        n = (size == size_byte) ? 1 : (size == size_half) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            ref_mem[a + 10'(i)] = wd[8*i +: 8];
        end
    endfunction

    function automatic logic [31:0] expect_load(mem_size_e size, logic uns, logic [9:0] a);
        logic [7:0] lo;
        logic [7:0] hi;
        logic       fill;
        lo = ref_mem[a];
        hi = ref_mem[a + 10'd1];
        case (size)
            size_byte: begin
                fill = lo[7] && !uns;
                return {{24{fill}}, lo};
            end
            size_half: begin
                fill = hi[7] && !uns;
                return {{16{fill}}, hi, lo};
            end
            default: begin
                return {ref_mem[a + 10'd3], ref_mem[a + 10'd2], hi, lo};
            end
        endcase
    endfunction

    task automatic access(string name, logic we, mem_size_e size, logic uns,
                          logic [31:0] a, logic [31:0] wd, output logic [31:0] rd);
        logic [3:0]  be_exp;
        logic [31:0] mask;
        be_exp = expect_be(size, a[1:0]);
        mask   = {{8{be_exp[3]}}, {8{be_exp[2]}}, {8{be_exp[1]}}, {8{be_exp[0]}}};
        @(negedge CLK);
        mem_req      = 1'b1;
        hz_data_req  = 1'b1;
        mem_we       = we;
        mem_size     = size;
        mem_unsigned = uns;
        addr         = a;
        wdata        = wd;
        #1;
        check({name, " req"}, 1, 32'(obi_req));
        // request fields stay put until the grant
        while (busy) begin
            if (obi_req) begin
                check({name, " addr"}, a & ~32'h3, obi_addr);
                check({name, " we"}, 32'(we), 32'(obi_we));
                check({name, " be"}, 32'(be_exp), 32'(obi_be));
                if (we) begin
                    check({name, " wdata"}, (wd << (8 * a[1:0])) & mask, obi_wdata & mask);
                end
            end
            @(negedge CLK);
            #1;
        end
        // busy drops only in the response cycle
        check({name, " rvalid"}, 1, 32'(obi_rvalid));
        check({name, " bus_err"}, 0, 32'(bus_err));
        rd = rdata;
        @(negedge CLK);
        mem_req     = 1'b0;
        hz_data_req = 1'b0;
    endtask

    task automatic test_reset_word();
        logic [31:0] rd;
        logic [31:0] wd;
        check("reset obi_req", 0, 32'(obi_req));
        check("reset busy", 0, 32'(busy));
        check("reset misaligned_err", 0, 32'(misaligned_err));
        check("reset bus_err", 0, 32'(bus_err));
        wd = $urandom;
        access("word store", 1'b1, size_word, 1'b0, 32'h40, wd, rd);
        ref_store(size_word, 10'h40, wd);
        access("word load", 1'b0, size_word, 1'b0, 32'h40, 32'h0, rd);
        check("word load data", wd, rd);
    endtask

    task automatic test_sub_word();
        logic [31:0] rd;
        logic [31:0] wd;
        for (int off = 0; off < 4; off++) begin
            wd    = $urandom;
            wd[7] = off[0];
            access("byte store", 1'b1, size_byte, 1'b0, 32'h80 + 32'(off), wd, rd);
            ref_store(size_byte, 10'h80 + 10'(off), wd);
        end
        // upper half first, so the lower half keeps its fill value for a while
        for (int off = 6; off >= 4; off -= 2) begin
            wd     = $urandom;
            wd[15] = off[1];
            access("half store", 1'b1, size_half, 1'b0, 32'h80 + 32'(off), wd, rd);
            ref_store(size_half, 10'h80 + 10'(off), wd);
            access("half neighbour", 1'b0, size_word, 1'b0, 32'h84, 32'h0, rd);
            check("half neighbour data", expect_load(size_word, 1'b0, 10'h84), rd);
        end
        for (int off = 0; off < 8; off++) begin
            for (int u = 0; u < 2; u++) begin
                access("byte load", 1'b0, size_byte, 1'(u), 32'h80 + 32'(off), 32'h0, rd);
                check("byte load data", expect_load(size_byte, 1'(u), 10'h80 + 10'(off)), rd);
                if (off % 2 == 0) begin
                    access("half load", 1'b0, size_half, 1'(u), 32'h80 + 32'(off), 32'h0, rd);
                    check("half load data",
                          expect_load(size_half, 1'(u), 10'h80 + 10'(off)), rd);
                end
            end
        end
    endtask

    task automatic test_random_delays();
        logic [31:0] rd;
        logic [31:0] wd;
        logic [31:0] a;
        logic        uns;
        mem_size_e   sz;
        for (int n = 0; n < 16; n++) begin
            gnt_delay = 4'($urandom_range(0, MAX_DELAY));
            rsp_delay = 4'($urandom_range(0, MAX_DELAY));
            sz  = mem_size_e'($urandom_range(0, 2));
            uns = 1'($urandom_range(0, 1));
            a   = 32'h100 + 32'($urandom_range(0, 63));
            a   = (sz == size_word) ? a & ~32'h3 : (sz == size_half) ? a & ~32'h1 : a;
            wd  = $urandom;
            if ($urandom_range(0, 1) == 1) begin
                access("delayed store", 1'b1, sz, 1'b0, a, wd, rd);
                ref_store(sz, a[9:0], wd);
            end else begin
                access("delayed load", 1'b0, sz, uns, a, 32'h0, rd);
                check("delayed load data", expect_load(sz, uns, a[9:0]), rd);
            end
        end
        gnt_delay = 4'd0;
        rsp_delay = 4'd0;
    endtask

    task automatic test_misaligned();
        logic [31:0] rd;
        for (int k = 0; k < 5; k++) begin
            @(negedge CLK);
            mem_req     = 1'b1;
            hz_data_req = 1'b1;
            mem_we      = 1'b1;
            mem_size    = (k < 2) ? size_half : size_word;
            addr        = 32'h1c0 + ((k < 2) ? 32'(2 * k + 1) : 32'(k - 1));
            wdata       = $urandom;
            #1;
            check("misaligned err", 1, 32'(misaligned_err));
            check("misaligned obi_req", 0, 32'(obi_req));
            check("misaligned busy", 0, 32'(busy));
            @(negedge CLK);
            mem_req     = 1'b0;
            hz_data_req = 1'b0;
            #1;
            check("misaligned pulse end", 0, 32'(misaligned_err));
            check("misaligned still idle", 0, 32'(busy));
        end
        access("misaligned readback", 1'b0, size_word, 1'b0, 32'h1c0, 32'h0, rd);
        check("misaligned readback data", expect_load(size_word, 1'b0, 10'h1c0), rd);
    endtask

    task automatic test_timeout();
        logic [31:0] rd;
        logic [31:0] wd;
        int          cycles;
        mute = 1'b1;
        @(negedge CLK);
        mem_req      = 1'b1;
        hz_data_req  = 1'b1;
        mem_we       = 1'b0;
        mem_size     = size_word;
        mem_unsigned = 1'b0;
        addr         = 32'h200;
        #1;
        cycles = 0;
        while (busy && cycles <= `LSU_TIMEOUT_CYCLES + 3) begin
            @(negedge CLK);
            #1;
            cycles++;
        end
        check("timeout bus_err", 1, 32'(bus_err));
        check("timeout busy", 0, 32'(busy));
        check("timeout obi_req", 0, 32'(obi_req));
        @(negedge CLK);
        mem_req     = 1'b0;
        hz_data_req = 1'b0;
        mute        = 1'b0;
        #1;
        check("timeout pulse end", 0, 32'(bus_err));
        wd = $urandom;
        access("after timeout store", 1'b1, size_word, 1'b0, 32'h200, wd, rd);
        access("after timeout load", 1'b0, size_word, 1'b0, 32'h200, 32'h0, rd);
        check("after timeout data", wd, rd);
    endtask

    initial begin
        void'($urandom(82567));
        errors       = 0;
        checks       = 0;
        RSTn         = 1'b0;
        mem_req      = 1'b0;
        hz_data_req  = 1'b0;
        mem_we       = 1'b0;
        mem_size     = size_word;
        mem_unsigned = 1'b0;
        addr         = '0;
        wdata        = '0;
        gnt_delay    = 4'd0;
        rsp_delay    = 4'd0;
        mute         = 1'b0;
        preload();
        repeat (5) @(posedge CLK);
        @(negedge CLK);
        RSTn = 1'b1;
        #1;
        test_reset_word();
        test_sub_word();
        test_random_delays();
        test_misaligned();
        test_timeout();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: tb_obi_mem.sv
`timescale 1ns/1ps
`include "lsu_consts.svh"

module tb_obi_mem (
    input  logic                 CLK,
    input  logic                 RSTn,
    input  logic [3:0]           gnt_delay,
    input  logic [3:0]           rsp_delay,
    input  logic                 mute,
    input  logic                 obi_req,
    input  logic                 obi_we,
    input  logic [`LSU_XLEN-1:0] obi_addr,
    input  logic [3:0]           obi_be,
    input  logic [`LSU_XLEN-1:0] obi_wdata,
    output logic                 obi_gnt,
    output logic                 obi_rvalid,
    output logic [`LSU_XLEN-1:0] obi_rdata
);

    // 256 words, filled by the testbench before reset ends
    logic [`LSU_XLEN-1:0] mem [0:255];
    logic [3:0]           req_age;
    logic [3:0]           rsp_age;
    logic                 pending;

    // a muted memory never grants
    assign obi_gnt    = obi_req && !mute && !pending && (req_age >= gnt_delay);
    assign obi_rvalid = pending && (rsp_age >= rsp_delay);

    always @(posedge CLK) begin
        if (!RSTn) begin
            req_age   <= '0;
            rsp_age   <= '0;
            pending   <= 1'b0;
            obi_rdata <= '0;
        end else if (obi_gnt) begin
            req_age   <= '0;
            rsp_age   <= '0;
            pending   <= 1'b1;
            obi_rdata <= mem[obi_addr[9:2]];
            for (int b = 0; b < 4; b++) begin
                if (obi_we && obi_be[b]) begin
                    mem[obi_addr[9:2]][8*b +: 8] <= obi_wdata[8*b +: 8];
                end
            end
        end else begin
            if (!obi_req) begin
                req_age <= '0;
            end else if (req_age != 4'hf) begin
                req_age <= req_age + 4'd1;
            end
            if (obi_rvalid) begin
                pending <= 1'b0;
            end else if (pending) begin
                rsp_age <= rsp_age + 4'd1;
            end
        end
    end

endmodule
